/* build.f */
verilog/procPkg.sv
verilog/procControl.sv
verilog/procRegisters.sv
verilog/procBus.sv
verilog/procAlu.sv
verilog/procTop.sv
bench/testMemory.sv
bench/procTb.sv

/* Bender.yml */
package:
  name: proc16

sources:
  - files:
      - verilog/procPkg.sv
      - verilog/procControl.sv
      - verilog/procRegisters.sv
      - verilog/procBus.sv
      - verilog/procAlu.sv
      - verilog/procTop.sv
  - target: test
    files:
      - bench/testMemory.sv
      - bench/procTb.sv

/* bench/procTb.sv */
// Bench for procTop with code from address 0 and data from 0x200, and Run stays high once raised
`timescale 1ns/1ps
`default_nettype none

module procTb;

    localparam int period = 4;
    localparam int resetCycles = 4;
    localparam int idleCycles = 6;    // Run held low after reset
    localparam int dataBase = 'h200;

    logic Clock, reset, Run, W, Done, fetchStart;
    logic [15:0] DIN, ADDR, DOUT;
    int writeCount, errorCount;
    int doneCount = 0;
    int pc = 0;
    int instrCount = 0;
    int cycleCount = 0;
    int expCount = 0;
    bit programBuilt = 1'b0;
    logic [15:0] image [0:1023] = '{default: '0};   // program copy for latency lookup
    logic [15:0] shadow [0:1023] = '{default: '0};  // expected data memory
    logic [15:0] expAddr [0:63];
    logic [15:0] expData [0:63];
    logic [15:0] regs [0:6] = '{default: '0};
    logic modelZ, modelN, modelC;

    procTop DUT (.Clock, .reset, .DIN, .Run, .ADDR, .DOUT, .W, .Done);

    testMemory memory (.Clock, .ADDR, .DOUT, .W, .DIN, .writeCount);

    assign fetchStart = Run && (DUT.control.step == procPkg::stepFetch);

    initial begin
        Clock = 1'b0;
        forever #(period / 2) Clock = ~Clock;
    end

    function automatic int latencyOf(input logic [15:0] word);
        if (word[15:13] == procPkg::opMv || (word[15:13] == procPkg::opMvt && word[12])) begin
            return 4;
        end
        if (word[15:13] == procPkg::opCmp) begin
            return 5;
        end
        return 6;  // alu ops, ld, st, branches
    endfunction

    task automatic reportValue(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        errorCount++;
        $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic reportFailure(input string what);
        errorCount++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    task automatic place(input logic [15:0] word, input bit executed);
        image[pc] = word;
        memory.loadWord(pc, word);
        pc++;
        if (executed) begin
            instrCount++;
            cycleCount += latencyOf(word);
        end
    endtask

    task automatic aluOp(input procPkg::instrOpcode op, input logic [2:0] rx, input bit useImm,
                         input logic [2:0] ry, input logic [8:0] imm);
        logic [15:0] a, b, r;
        logic c;
        a = regs[rx];
        b = useImm ? {{7{imm[8]}}, imm} : regs[ry];
        case (op)
            procPkg::opAdd: {c, r} = a + b;
            procPkg::opAnd: begin
                r = a & b;
                c = 1'b0;
            end
            default: begin
                r = a - b;
                c = (a >= b);  // no borrow
            end
        endcase
        modelZ = (r == 16'h0000);
        modelN = r[15];
        modelC = c;
        if (op != procPkg::opCmp) begin
            regs[rx] = r;
        end
        place({op, useImm, rx, useImm ? imm : {6'b0, ry}}, 1'b1);
    endtask

    task automatic setReg(input logic [2:0] rx, input logic [15:0] value);
        regs[rx] = {value[15:8], 8'h00};
        place({procPkg::opMvt, 1'b1, rx, 1'b0, value[15:8]}, 1'b1);
        aluOp(procPkg::opAdd, rx, 1'b1, 3'd0, {1'b0, value[7:0]});
    endtask

    task automatic mvReg(input logic [2:0] rx, input logic [2:0] ry);
        regs[rx] = regs[ry];
        place({procPkg::opMv, 1'b0, rx, 6'b0, ry}, 1'b1);
    endtask

    task automatic store(input logic [2:0] rx, input logic [2:0] ry, input bit executed);
        if (executed) begin
            expAddr[expCount] = regs[ry];
            expData[expCount] = regs[rx];
            shadow[regs[ry][9:0]] = regs[rx];
            expCount++;
        end
        place({procPkg::opSt, 1'b0, rx, 6'b0, ry}, executed);
    endtask

    task automatic load(input logic [2:0] rx, input logic [2:0] ry);
        regs[rx] = shadow[regs[ry][9:0]];
        place({procPkg::opLd, 1'b0, rx, 6'b0, ry}, 1'b1);
    endtask

    // a taken branch jumps over the marker store
    task automatic branchOverStore(input procPkg::branchCond cond);
        bit taken;
        case (cond)
            procPkg::condAlways: taken = 1'b1;
            procPkg::condEq:     taken = modelZ;
            procPkg::condNe:     taken = !modelZ;
            procPkg::condCc:     taken = !modelC;
            procPkg::condCs:     taken = modelC;
            procPkg::condPl:     taken = !modelN;
            procPkg::condMi:     taken = modelN;
            default:             taken = 1'b0;
        endcase
        place({procPkg::opMvt, 1'b0, cond, 9'd1}, 1'b1);
        store(3'd1, 3'd6, !taken);
    endtask

    task automatic buildProgram();
        procPkg::instrOpcode op;
        logic [15:0] x, y, lo, hi;
        setReg(6, dataBase);  // r6 walks the data area
        repeat (2) begin
            setReg(1, $urandom);
            setReg(2, $urandom);
            for (int k = 0; k < 3; k++) begin
                op = (k == 0) ? procPkg::opAdd : (k == 1) ? procPkg::opSub : procPkg::opAnd;
                mvReg(3, 1);
                aluOp(op, 3, 1'b0, 2, 9'd0);
                store(3, 6, 1'b1);
                aluOp(procPkg::opAdd, 6, 1'b1, 0, 9'd1);
                mvReg(4, 2);
                aluOp(op, 4, 1'b1, 0, $urandom);
                store(4, 6, 1'b1);
                aluOp(procPkg::opAdd, 6, 1'b1, 0, 9'd1);
            end
        end
        setReg(5, dataBase + 3);  // sub result of the first pass
        load(0, 5);
        store(0, 6, 1'b1);
        aluOp(procPkg::opAdd, 6, 1'b1, 0, 9'd1);
        x = $urandom;
        y = $urandom;
        lo = (x < y) ? x : y;
        hi = (x < y) ? y : x;
        for (int p = 0; p < 3; p++) begin
            setReg(1, (p == 2) ? hi : lo);
            setReg(2, (p == 1) ? hi : lo);
            for (int cond = 0; cond < 8; cond++) begin
                aluOp(procPkg::opCmp, 1, 1'b0, 2, 9'd0);
                branchOverStore(procPkg::branchCond'(cond));
                aluOp(procPkg::opAdd, 6, 1'b1, 0, 9'd1);
            end
        end
        setReg(3, hi);
        setReg(4, lo);
        aluOp(procPkg::opSub, 3, 1'b0, 4, 9'd0);  // no borrow, c set
        branchOverStore(procPkg::condCs);
        store(3, 6, 1'b1);
    endtask

    always @(posedge Clock) begin
        if (reset) begin
            doneCount <= 0;
        end else if (Done) begin
            doneCount <= doneCount + 1;
        end
    end

    assert property (@(posedge Clock) disable iff (reset) !Run |-> ADDR == 16'h0000)
        else reportValue("ADDR", 16'h0000, $sampled(ADDR));
    assert property (@(posedge Clock) disable iff (reset) !Run |-> !W && !Done)
        else reportFailure("W or Done went high while Run was low");
    assert property (@(posedge Clock) disable iff (reset) W |-> ADDR == expAddr[writeCount])
        else reportValue("ADDR", expAddr[$sampled(writeCount)], $sampled(ADDR));
    assert property (@(posedge Clock) disable iff (reset) W |-> DOUT == expData[writeCount])
        else reportValue("DOUT", expData[$sampled(writeCount)], $sampled(DOUT));

    // ADDR holds the fetched address one cycle after the fetch step
    assert property (@(posedge Clock) disable iff (reset)
        fetchStart ##1 (latencyOf(image[ADDR[9:0]]) == 4) |-> !Done [*2] ##1 Done)
        else reportFailure("Done did not come 4 cycles after the fetch");
    assert property (@(posedge Clock) disable iff (reset)
        fetchStart ##1 (latencyOf(image[ADDR[9:0]]) == 5) |-> !Done [*3] ##1 Done)
        else reportFailure("Done did not come 5 cycles after the fetch");
    assert property (@(posedge Clock) disable iff (reset)
        fetchStart ##1 (latencyOf(image[ADDR[9:0]]) == 6) |-> !Done [*4] ##1 Done)
        else reportFailure("Done did not come 6 cycles after the fetch");

    initial begin
        wait (programBuilt);
        #((resetCycles + idleCycles + cycleCount * 3 / 2 + 4) * period);
        $display("Timeout with %0d of %0d instructions done", doneCount, instrCount);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        reset = 1'b1;
        Run = 1'b0;
        errorCount = 0;
        void'($urandom(32'hdea6));
        buildProgram();
        programBuilt = 1'b1;
        repeat (resetCycles) @(posedge Clock);
        #1 reset = 1'b0;
        repeat (idleCycles) @(posedge Clock);
        #1 Run = 1'b1;
        while (doneCount < instrCount) begin
            @(posedge Clock);
        end
        repeat (2) @(posedge Clock);
        assert (writeCount == expCount)
            else reportFailure($sformatf("%0d writes seen, %0d expected", writeCount, expCount));
        $display("Summary with %0d errors over %0d instructions and %0d writes",
                 errorCount, instrCount, writeCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/testMemory.sv */
// Word memory of 1024 entries with one cycle of read latency, ADDR wraps above bit 9
`timescale 1ns/1ps
`default_nettype none

module testMemory (
    input  logic        Clock,
    input  logic [15:0] ADDR,
    input  logic [15:0] DOUT,
    input  logic        W,
    output logic [15:0] DIN,
    output int          writeCount
);

    localparam int depth = 1024;

    logic [15:0] mem [0:depth-1] = '{default: '0};

    initial begin
        DIN = '0;
        writeCount = 0;
    end

    always @(posedge Clock) begin
        if (W) begin
            mem[ADDR[9:0]] <= DOUT;
            writeCount <= writeCount + 1;
        end
        DIN <= mem[ADDR[9:0]];  // old word on a read during write
    end

    // program loading before the clock starts mattering
    task automatic loadWord(input int address, input logic [15:0] word);
        mem[address] = word;
    endtask

endmodule

`default_nettype wire

/* verilog/procTop.sv */
// Processor top level for a synchronous memory with one cycle of read latency and no handshake but Run
`timescale 1ns/1ps
`default_nettype none

module procTop (
    input  logic                            Clock,
    input  logic                            reset,
    input  logic [procPkg::dataWidth-1:0]   DIN,
    input  logic                            Run,
    output logic [procPkg::dataWidth-1:0]   ADDR,
    output logic [procPkg::dataWidth-1:0]   DOUT,
    output logic                            W,
    output logic                            Done
);

    logic [procPkg::dataWidth-1:0] instrWord, Bus, G;
    logic [procPkg::regCount-1:0][procPkg::dataWidth-1:0] regValues;
    logic [procPkg::regCount-1:0] regLoad;
    procPkg::busSelect busSel;
    logic flagZ, flagN, flagC;
    logic pcIncrement, irLoad, addrLoad, doutLoad, writeNext;
    logic aLoad, gLoad, flagsLoad, subtract, andOp;

    procControl control (
        .Clock, .reset, .Run, .instrWord, .flagZ, .flagN, .flagC,
        .busSel, .regLoad, .pcIncrement, .irLoad, .addrLoad, .doutLoad, .writeNext,
        .aLoad, .gLoad, .flagsLoad, .subtract, .andOp, .Done
    );

    procRegisters registers (
        .Clock, .reset, .Bus, .regLoad, .pcIncrement, .regValues
    );

    procBus bus (
        .Clock, .reset, .DIN, .regValues, .G, .busSel,
        .irLoad, .addrLoad, .doutLoad, .writeNext,
        .instrWord, .Bus, .ADDR, .DOUT, .W
    );

    procAlu alu (
        .Clock, .reset, .Bus, .aLoad, .gLoad, .flagsLoad, .subtract, .andOp,
        .G, .flagZ, .flagN, .flagC
    );

endmodule

`default_nettype wire

/* verilog/procAlu.sv */
// Add, subtract and AND unit with A, G and flag registers; flags change only when flagsLoad is high
`timescale 1ns/1ps
`default_nettype none

module procAlu (
    input  logic                            Clock,
    input  logic                            reset,
    input  logic [procPkg::dataWidth-1:0]   Bus,
    input  logic                            aLoad,
    input  logic                            gLoad,
    input  logic                            flagsLoad,
    input  logic                            subtract,
    input  logic                            andOp,
    output logic [procPkg::dataWidth-1:0]   G,
    output logic                            flagZ,
    output logic                            flagN,
    output logic                            flagC
);

    logic [procPkg::dataWidth-1:0] aReg;
    logic [procPkg::dataWidth-1:0] result;
    logic carry;

    always_ff @(posedge Clock) begin
        if (aLoad) begin
            aReg <= Bus;
        end
    end

    always_comb begin
        if (andOp) begin
            {carry, result} = {1'b0, aReg & Bus};  // and clears c
        end else if (subtract) begin
            {carry, result} = {1'b0, aReg} + {1'b0, ~Bus} + 1'b1;  // carry means no borrow
        end else begin
            {carry, result} = {1'b0, aReg} + {1'b0, Bus};
        end
    end

    always_ff @(posedge Clock) begin
        if (gLoad) begin
            G <= result;
        end
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            flagZ <= 1'b0;
            flagN <= 1'b0;
            flagC <= 1'b0;
        end else if (flagsLoad) begin
            flagZ <= (result == '0);
            flagN <= result[procPkg::dataWidth-1];
            flagC <= carry;
        end
    end

endmodule

`default_nettype wire

/* verilog/procBus.sv */
// Internal bus mux with IR and memory port registers; memory must return DIN one cycle after ADDR
`timescale 1ns/1ps
`default_nettype none

module procBus (
    input  logic                                                Clock,
    input  logic                                                reset,
    input  logic [procPkg::dataWidth-1:0]                       DIN,
    input  logic [procPkg::regCount-1:0][procPkg::dataWidth-1:0] regValues,
    input  logic [procPkg::dataWidth-1:0]                       G,
    input  procPkg::busSelect                                   busSel,
    input  logic                                                irLoad,
    input  logic                                                addrLoad,
    input  logic                                                doutLoad,
    input  logic                                                writeNext,
    output logic [procPkg::dataWidth-1:0]                       instrWord,
    output logic [procPkg::dataWidth-1:0]                       Bus,
    output logic [procPkg::dataWidth-1:0]                       ADDR,
    output logic [procPkg::dataWidth-1:0]                       DOUT,
    output logic                                                W
);

    localparam int byteWidth = procPkg::dataWidth / 2;

    logic [procPkg::dataWidth-1:0] immSigned;
    logic [procPkg::dataWidth-1:0] immHigh;

    always_ff @(posedge Clock) begin
        if (irLoad) begin
            instrWord <= DIN;
        end
    end

    assign immSigned = {{(procPkg::dataWidth - procPkg::immWidth){instrWord[procPkg::immMsb]}},
                        instrWord[procPkg::immMsb:procPkg::immLsb]};
    assign immHigh = {instrWord[byteWidth-1:0], {byteWidth{1'b0}}};  // mvt operand

    always_comb begin
        case (busSel)
            procPkg::selR0, procPkg::selR1, procPkg::selR2, procPkg::selR3,
            procPkg::selR4, procPkg::selR5, procPkg::selR6, procPkg::selPc:
                Bus = regValues[busSel[procPkg::regIndexWidth-1:0]];
            procPkg::selG:         Bus = G;
            procPkg::selImmSigned: Bus = immSigned;
            procPkg::selImmHigh:   Bus = immHigh;
            procPkg::selDin:       Bus = DIN;
            default:               Bus = '0;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            ADDR <= '0;
            DOUT <= '0;
            W <= 1'b0;
        end else begin
            if (addrLoad) begin
                ADDR <= Bus;
            end
            if (doutLoad) begin
                DOUT <= Bus;
            end
            W <= writeNext;  // one pulse per st
        end
    end

    assert property (@(posedge Clock) disable iff (reset) W |=> !W);

endmodule

`default_nettype wire

/* verilog/procRegisters.sv */
// Register file r0 to r6 plus the program counter; a load of r7 takes priority over its increment
`timescale 1ns/1ps
`default_nettype none

module procRegisters (
    input  logic                                                Clock,
    input  logic                                                reset,
    input  logic [procPkg::dataWidth-1:0]                       Bus,
    input  logic [procPkg::regCount-1:0]                        regLoad,
    input  logic                                                pcIncrement,
    output logic [procPkg::regCount-1:0][procPkg::dataWidth-1:0] regValues
);

    logic [procPkg::pcIndex-1:0][procPkg::dataWidth-1:0] generalRegs;  // r0 to r6
    logic [procPkg::dataWidth-1:0] pc;

    always_ff @(posedge Clock) begin
        if (reset) begin
            generalRegs <= '0;
        end else begin
            for (int i = 0; i < procPkg::pcIndex; i++) begin
                if (regLoad[i]) begin
                    generalRegs[i] <= Bus;
                end
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            pc <= '0;
        end else if (regLoad[procPkg::pcIndex]) begin
            pc <= Bus;  // mv to r7 or taken branch
        end else if (pcIncrement) begin
            pc <= pc + 1'b1;
        end
    end

    assign regValues = {pc, generalRegs};  // pc lands at index 7

    // increment happens only at fetch, loads only in execute steps
    assert property (@(posedge Clock) disable iff (reset)
        !(regLoad[procPkg::pcIndex] && pcIncrement));

endmodule

`default_nettype wire

/* verilog/procControl.sv */
// Step FSM and decoder; Run is sampled only in stepFetch and ld/st ignore the immediate flag
`timescale 1ns/1ps
`default_nettype none

module procControl (
    input  logic                            Clock,
    input  logic                            reset,
    input  logic                            Run,
    input  logic [procPkg::dataWidth-1:0]   instrWord,
    input  logic                            flagZ,
    input  logic                            flagN,
    input  logic                            flagC,
    output procPkg::busSelect               busSel,
    output logic [procPkg::regCount-1:0]    regLoad,
    output logic                            pcIncrement,
    output logic                            irLoad,
    output logic                            addrLoad,
    output logic                            doutLoad,
    output logic                            writeNext,
    output logic                            aLoad,
    output logic                            gLoad,
    output logic                            flagsLoad,
    output logic                            subtract,
    output logic                            andOp,
    output logic                            Done
);

    procPkg::timeStep step, nextStep;
    procPkg::instrOpcode opcode;
    logic immFlag;
    logic [procPkg::regIndexWidth-1:0] rX, rY;
    logic rxLoad;       // write the register named by rX
    logic branchTaken;  // load pc from G
    logic condMet;
    logic isBranch;

    function automatic procPkg::busSelect regSel(input logic [procPkg::regIndexWidth-1:0] index);
        return procPkg::busSelect'({1'b0, index});
    endfunction

    assign opcode = procPkg::instrOpcode'(instrWord[procPkg::opcodeMsb:procPkg::opcodeLsb]);
    assign immFlag = instrWord[procPkg::immFlagBit];
    assign rX = instrWord[procPkg::rxMsb:procPkg::rxLsb];
    assign rY = instrWord[procPkg::ryMsb:procPkg::ryLsb];
    assign isBranch = (opcode == procPkg::opMvt) && !immFlag;

    always_comb begin
        case (procPkg::branchCond'(rX))
            procPkg::condAlways: condMet = 1'b1;
            procPkg::condEq:     condMet = flagZ;
            procPkg::condNe:     condMet = !flagZ;
            procPkg::condCc:     condMet = !flagC;
            procPkg::condCs:     condMet = flagC;
            procPkg::condPl:     condMet = !flagN;
            procPkg::condMi:     condMet = flagN;
            procPkg::condNever:  condMet = 1'b0;
            default:             condMet = 1'b0;
        endcase
    end

    always_comb begin
        case (step)
            procPkg::stepFetch:  nextStep = Run ? procPkg::stepWait : procPkg::stepFetch;
            procPkg::stepWait:   nextStep = procPkg::stepLoadIr;
            procPkg::stepLoadIr: nextStep = procPkg::stepExec1;
            procPkg::stepExec1:  nextStep = Done ? procPkg::stepFetch : procPkg::stepExec2;
            procPkg::stepExec2:  nextStep = Done ? procPkg::stepFetch : procPkg::stepExec3;
            default:             nextStep = procPkg::stepFetch;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            step <= procPkg::stepFetch;
        end else begin
            step <= nextStep;
        end
    end

    always_comb begin
        busSel = procPkg::busSelect'(4'bxxxx);  // don't care when nothing loads
        rxLoad = 1'b0;
        branchTaken = 1'b0;
        pcIncrement = 1'b0;
        irLoad = 1'b0;
        addrLoad = 1'b0;
        doutLoad = 1'b0;
        writeNext = 1'b0;
        aLoad = 1'b0;
        gLoad = 1'b0;
        flagsLoad = 1'b0;
        subtract = 1'b0;
        andOp = 1'b0;
        Done = 1'b0;
        case (step)
            procPkg::stepFetch: begin
                busSel = procPkg::selPc;
                addrLoad = 1'b1;
                pcIncrement = Run;
            end
            procPkg::stepLoadIr: begin
                busSel = procPkg::selDin;  // DIN holds the instruction now
                irLoad = 1'b1;
            end
            procPkg::stepExec1: begin
                case (opcode)
                    procPkg::opMv: begin
                        busSel = immFlag ? procPkg::selImmSigned : regSel(rY);
                        rxLoad = 1'b1;
                        Done = 1'b1;
                    end
                    procPkg::opMvt: begin
                        busSel = isBranch ? procPkg::selPc : procPkg::selImmHigh;
                        aLoad = isBranch;  // pc already points past the branch
                        rxLoad = !isBranch;
                        Done = !isBranch;
                    end
                    procPkg::opLd, procPkg::opSt: begin
                        busSel = regSel(rY);
                        addrLoad = 1'b1;
                    end
                    default: begin  // add, sub, and, cmp
                        busSel = regSel(rX);
                        aLoad = 1'b1;
                    end
                endcase
            end
            procPkg::stepExec2: begin
                case (opcode)
                    procPkg::opMvt: begin
                        busSel = procPkg::selImmSigned;  // branch offset
                        gLoad = 1'b1;
                    end
                    procPkg::opAdd, procPkg::opSub, procPkg::opAnd, procPkg::opCmp: begin
                        busSel = immFlag ? procPkg::selImmSigned : regSel(rY);
                        subtract = (opcode == procPkg::opSub) || (opcode == procPkg::opCmp);
                        andOp = (opcode == procPkg::opAnd);
                        gLoad = (opcode != procPkg::opCmp);
                        flagsLoad = 1'b1;
                        Done = (opcode == procPkg::opCmp);
                    end
                    procPkg::opSt: begin
                        busSel = regSel(rX);
                        doutLoad = 1'b1;
                        writeNext = 1'b1;  // W rises next cycle
                    end
                    default: ;  // ld waits for memory
                endcase
            end
            procPkg::stepExec3: begin
                Done = 1'b1;
                case (opcode)
                    procPkg::opMvt: begin
                        busSel = procPkg::selG;
                        branchTaken = condMet;
                    end
                    procPkg::opLd: begin
                        busSel = procPkg::selDin;
                        rxLoad = 1'b1;
                    end
                    procPkg::opSt: ;
                    default: begin
                        busSel = procPkg::selG;
                        rxLoad = 1'b1;
                    end
                endcase
            end
            default: ;
        endcase
    end

    always_comb begin
        for (int i = 0; i < procPkg::regCount; i++) begin
            regLoad[i] = (rxLoad && rX == i) || (i == procPkg::pcIndex && branchTaken);
        end
    end

    // each Done ends its instruction in an execute step
    assert property (@(posedge Clock) disable iff (reset)
        Done |-> (step inside {procPkg::stepExec1, procPkg::stepExec2, procPkg::stepExec3})
            ##1 (step == procPkg::stepFetch));

    assert property (@(posedge Clock) disable iff (reset)
        $onehot0(regLoad[procPkg::pcIndex-1:0]));

    assert property (@(posedge Clock) disable iff (reset)
        (|regLoad || irLoad || addrLoad || doutLoad || aLoad || gLoad || flagsLoad)
            |-> !$isunknown(busSel));

endmodule

`default_nettype wire

/* verilog/procPkg.sv */
// Encodings and field positions for the 16-bit multicycle processor, with r7 as the program counter
`default_nettype none

package procPkg;

    localparam int dataWidth = 16;     // data word, bus and address
    localparam int regIndexWidth = 3;
    localparam int regCount = 8;
    localparam int pcIndex = 7;        // r7 is the program counter
    localparam int immWidth = 9;

    // instruction field positions
    localparam int opcodeMsb = 15;
    localparam int opcodeLsb = 13;
    localparam int immFlagBit = 12;
    localparam int rxMsb = 11;
    localparam int rxLsb = 9;
    localparam int ryMsb = 2;
    localparam int ryLsb = 0;
    localparam int immMsb = 8;
    localparam int immLsb = 0;

    typedef enum logic [2:0] {
        opMv, opMvt, opAdd, opSub, opLd, opSt, opAnd, opCmp
    } instrOpcode;

    // held in the rX field of a branch (mvt with immediate flag clear)
    typedef enum logic [2:0] {
        condAlways, condEq, condNe, condCc, condCs, condPl, condMi, condNever
    } branchCond;

    typedef enum logic [2:0] {
        stepFetch, stepWait, stepLoadIr, stepExec1, stepExec2, stepExec3
    } timeStep;

    typedef enum logic [3:0] {
        selR0, selR1, selR2, selR3, selR4, selR5, selR6, selPc,
        selG, selImmSigned, selImmHigh, selDin
    } busSelect;

endpackage

`default_nettype wire
